// File: hdl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int XLEN      = 32;
    localparam int OFF_W     = 12;
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    // Loads use codes 0 to 4 and stores use 5 to 7
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } lsu_op_e;

    function automatic logic op_is_store(lsu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // Access size in bytes
    function automatic logic [2:0] op_size(lsu_op_e op);
        logic [2:0] size;
        case (op)
            OP_LB, OP_LBU, OP_SB: begin
                size = 3'd1;
            end
            OP_LH, OP_LHU, OP_SH: begin
                size = 3'd2;
            end
            default: begin
                size = 3'd4;
            end
        endcase
        return size;
    endfunction

endpackage

`default_nettype wire

// File: hdl/lsu_agu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_agu
    import lsu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               advance,
    input  wire               in_valid,
    input  wire lsu_op_e      op,
    input  wire [XLEN-1:0]    base,
    input  wire [OFF_W-1:0]   offset,
    input  wire [XLEN-1:0]    wdata,
    output logic              s1_valid,
    output lsu_op_e           s1_op,
    output logic [XLEN-1:0]   s1_addr,
    output logic [3:0]        s1_be,
    output logic [XLEN-1:0]   s1_wdata,
    output logic              s1_err
);

    logic [XLEN-1:0] ea;
    logic [2:0]      size;
    logic            misaligned;
    logic [3:0]      be;
    logic [XLEN-1:0] lane_data;

    assign ea   = base + {{(XLEN-OFF_W){offset[OFF_W-1]}}, offset};
    assign size = op_size(op);

    always_comb begin
        case (size)
            3'd2: begin
                misaligned = ea[0];
            end
            3'd4: begin
                misaligned = |ea[1:0];
            end
            default: begin
                misaligned = 1'b0;
            end
        endcase
    end

    // Store data is copied into every lane of its size and the mask picks the real one
    always_comb begin
        case (size)
            3'd1: begin
                be        = 4'b0001 << ea[1:0];
                lane_data = {4{wdata[7:0]}};
            end
            3'd2: begin
                be        = 4'b0011 << ea[1:0];
                lane_data = {2{wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = wdata;
            end
        endcase
        if (!op_is_store(op) || misaligned) begin
            be = 4'b0000;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
        end
    end

    // Request payload moves in step with the valid bit
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_op    <= op;
            s1_addr  <= ea;
            s1_be    <= be;
            s1_wdata <= lane_data;
            s1_err   <= misaligned;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_sram.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sram
    import lsu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               advance,
    input  wire               s1_valid,
    input  wire lsu_op_e      s1_op,
    input  wire [XLEN-1:0]    s1_addr,
    input  wire [3:0]         s1_be,
    input  wire [XLEN-1:0]    s1_wdata,
    input  wire               s1_err,
    output logic              s2_valid,
    output lsu_op_e           s2_op,
    output logic [1:0]        s2_byte_off,
    output logic [XLEN-1:0]   s2_rword,
    output logic              s2_err
);

    logic [XLEN-1:0]   mem [MEM_WORDS];
    logic [MEM_AW-1:0] word_idx;

    // Upper address bits are dropped, so the array is mirrored across the space
    assign word_idx = s1_addr[MEM_AW+1:2];

    // Write happens as the store leaves stage 1, so a load right behind it
    // reads the new contents on the following edge
    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            for (int i = 0; i < 4; i++) begin
                if (s1_be[i]) begin
                    mem[word_idx][8*i +: 8] <= s1_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_rword <= mem[word_idx];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (advance) begin
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            s2_op       <= s1_op;
            s2_byte_off <= s1_addr[1:0];
            s2_err      <= s1_err;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align
    import lsu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               advance,
    input  wire               s2_valid,
    input  wire lsu_op_e      s2_op,
    input  wire [1:0]         s2_byte_off,
    input  wire [XLEN-1:0]    s2_rword,
    input  wire               s2_err,
    output logic              out_valid,
    output logic [XLEN-1:0]   rdata,
    output logic              err
);

    logic [XLEN-1:0] shifted;
    logic [XLEN-1:0] result;
    logic            sign_ext;

    // Bring the addressed byte or halfword down to bit 0
    assign shifted  = s2_rword >> {s2_byte_off, 3'b000};
    assign sign_ext = (s2_op == OP_LB) || (s2_op == OP_LH);

    always_comb begin
        case (op_size(s2_op))
            3'd1: begin
                result = {{(XLEN-8){sign_ext & shifted[7]}}, shifted[7:0]};
            end
            3'd2: begin
                result = {{(XLEN-16){sign_ext & shifted[15]}}, shifted[15:0]};
            end
            default: begin
                result = s2_rword;
            end
        endcase
        // Stores and faulted accesses answer with zero
        if (op_is_store(s2_op) || s2_err) begin
            result = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            rdata <= result;
            err   <= s2_err;
        end
    end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               in_valid,
    output logic              in_ready,
    input  wire lsu_op_e      op,
    input  wire [XLEN-1:0]    base,
    input  wire [OFF_W-1:0]   offset,
    input  wire [XLEN-1:0]    wdata,
    output logic              out_valid,
    input  wire               out_ready,
    output logic [XLEN-1:0]   rdata,
    output logic              err
);

    logic            advance;

    logic            s1_valid;
    lsu_op_e         s1_op;
    logic [XLEN-1:0] s1_addr;
    logic [3:0]      s1_be;
    logic [XLEN-1:0] s1_wdata;
    logic            s1_err;

    logic            s2_valid;
    lsu_op_e         s2_op;
    logic [1:0]      s2_byte_off;
    logic [XLEN-1:0] s2_rword;
    logic            s2_err;

    // The whole pipeline stalls together only while a response is held
    assign advance  = !out_valid || out_ready;
    assign in_ready = advance;

    lsu_agu u_agu (
        .clk      (clk),
        .rst_n    (rst_n),
        .advance  (advance),
        .in_valid (in_valid),
        .op       (op),
        .base     (base),
        .offset   (offset),
        .wdata    (wdata),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_addr  (s1_addr),
        .s1_be    (s1_be),
        .s1_wdata (s1_wdata),
        .s1_err   (s1_err)
    );

    lsu_sram u_sram (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .s1_valid    (s1_valid),
        .s1_op       (s1_op),
        .s1_addr     (s1_addr),
        .s1_be       (s1_be),
        .s1_wdata    (s1_wdata),
        .s1_err      (s1_err),
        .s2_valid    (s2_valid),
        .s2_op       (s2_op),
        .s2_byte_off (s2_byte_off),
        .s2_rword    (s2_rword),
        .s2_err      (s2_err)
    );

    lsu_load_align u_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .advance     (advance),
        .s2_valid    (s2_valid),
        .s2_op       (s2_op),
        .s2_byte_off (s2_byte_off),
        .s2_rword    (s2_rword),
        .s2_err      (s2_err),
        .out_valid   (out_valid),
        .rdata       (rdata),
        .err         (err)
    );

endmodule

`default_nettype wire

// File: verif/lsu_sva.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_sva
    import lsu_pkg::*;
(
    input wire            clk,
    input wire            rst_n,
    input wire            in_ready,
    input wire            out_valid,
    input wire            out_ready,
    input wire [XLEN-1:0] rdata,
    input wire            err
);

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high while reset is applied");
        end

    // The pipeline is empty when reset lifts, so nothing can come out one cycle later
    reset_release: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high in the cycle after reset");
        end

    response_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(rdata) && $stable(err)))
        else begin
            fail_count++;
            $error("response changed while stalled");
        end

    ready_rule: assert property (@(posedge clk)
        in_ready == !(out_valid && !out_ready))
        else begin
            fail_count++;
            $error("in_ready does not follow the stall condition");
        end

endmodule

bind lsu_top lsu_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .rdata     (rdata),
    .err       (err)
);

`default_nettype wire

// File: verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int MAX_CYCLES = 4000;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    logic             in_ready;
    lsu_op_e          op;
    logic [XLEN-1:0]  base;
    logic [OFF_W-1:0] offset;
    logic [XLEN-1:0]  wdata;
    logic             out_valid;
    logic             out_ready;
    logic [XLEN-1:0]  rdata;
    logic             err;

    // Byte-wide reference copy of the data memory
    logic [7:0]       ref_mem [MEM_WORDS*4];

    logic [XLEN-1:0]  exp_rdata_q [$];
    logic             exp_err_q [$];
    int               exp_cyc_q [$];
    bit               exp_lat_q [$];
    string            exp_name_q [$];

    string            test_name;
    bit               ready_random = 1'b0;
    bit               lat_check = 1'b0;
    int               cycle = 0;
    int               mismatches = 0;
    int               other_errors = 0;

    lsu_top u_lsu_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .op        (op),
        .base      (base),
        .offset    (offset),
        .wdata     (wdata),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .rdata     (rdata),
        .err       (err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic print_counts();
        $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatches, other_errors, u_lsu_top.u_sva.fail_count);
    endtask

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with %0d responses missing",
                     cycle, exp_rdata_q.size());
            print_counts();
            $display("sim failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        #1;
        if (ready_random) begin
            out_ready = ($urandom_range(0, 1) == 1);
        end else begin
            out_ready = 1'b1;
        end
    end

    // Expected response of an accepted request with the model memory updated in request order
    task automatic predict();
        logic [XLEN-1:0] ea;
        logic [XLEN-1:0] raw;
        logic [XLEN-1:0] exp_rdata;
        logic            bad;
        int              ba;
        int              nb;
        ea        = base + {{(XLEN-OFF_W){offset[OFF_W-1]}}, offset};
        ba        = int'(ea[MEM_AW+1:0]);
        nb        = int'(op_size(op));
        bad       = (nb == 2 && ea[0]) || (nb == 4 && ea[1:0] != 2'b00);
        raw       = '0;
        exp_rdata = '0;
        if (!bad && op_is_store(op)) begin
            for (int i = 0; i < nb; i++) begin
                ref_mem[ba + i] = wdata[8*i +: 8];
            end
        end else if (!bad) begin
            for (int i = 0; i < nb; i++) begin
                raw[8*i +: 8] = ref_mem[ba + i];
            end
            case (op)
                OP_LB:   exp_rdata = {{24{raw[7]}}, raw[7:0]};
                OP_LH:   exp_rdata = {{16{raw[15]}}, raw[15:0]};
                OP_LBU:  exp_rdata = {24'b0, raw[7:0]};
                OP_LHU:  exp_rdata = {16'b0, raw[15:0]};
                default: exp_rdata = raw;
            endcase
        end
        exp_rdata_q.push_back(exp_rdata);
        exp_err_q.push_back(bad);
        exp_cyc_q.push_back(cycle);
        exp_lat_q.push_back(lat_check);
        exp_name_q.push_back(test_name);
    endtask

    task automatic check_response();
        logic [XLEN-1:0] exp_rdata;
        logic            exp_err;
        int              acc_cyc;
        bit              lat_on;
        string           name;
        if (exp_rdata_q.size() == 0) begin
            other_errors++;
            $display("response arrived with no request outstanding");
        end else begin
            exp_rdata = exp_rdata_q.pop_front();
            exp_err   = exp_err_q.pop_front();
            acc_cyc   = exp_cyc_q.pop_front();
            lat_on    = exp_lat_q.pop_front();
            name      = exp_name_q.pop_front();
            assert (rdata === exp_rdata) else begin
                mismatches++;
                $display("mismatch %s rdata expected %h actual %h", name, exp_rdata, rdata);
            end
            assert (err === exp_err) else begin
                mismatches++;
                $display("mismatch %s err expected %0b actual %0b", name, exp_err, err);
            end
            if (lat_on) begin
                assert (cycle - acc_cyc == 3) else begin
                    mismatches++;
                    $display("mismatch %s latency expected 3 actual %0d", name,
                             cycle - acc_cyc);
                end
            end
        end
    endtask

    // Inputs only move just after a rising edge, so the falling edge sees
    // exactly what the next rising edge will transfer
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                check_response();
            end
            if (in_valid && in_ready) begin
                predict();
            end
        end
    end

    task automatic send(input lsu_op_e o, input logic [XLEN-1:0] b,
                        input logic [OFF_W-1:0] off, input logic [XLEN-1:0] wd);
        in_valid = 1'b1;
        op       = o;
        base     = b;
        offset   = off;
        wdata    = wd;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        while (exp_rdata_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    initial begin
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] pattern;
        int              gap;
        void'($urandom(95416));
        rst_n     = 1'b1;
        in_valid  = 1'b0;
        op        = OP_LW;
        base      = '0;
        offset    = '0;
        wdata     = '0;
        out_ready = 1'b1;
        test_name = "reset";
        #1;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(1);

        // High address bits vary because the memory mirrors across the address space
        test_name = "word_round_trip";
        for (int i = 0; i < MEM_WORDS; i++) begin
            send(OP_SW, ($urandom() << (MEM_AW + 2)) | (i * 4), '0, $urandom());
        end
        for (int i = 0; i < 16; i++) begin
            send(OP_SW, $urandom_range(0, MEM_WORDS - 1) * 4, '0, $urandom());
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            send(OP_LW, i * 4 + 16, 12'hFF0, '0);
        end

        test_name = "byte_halfword_store";
        for (int k = 0; k < 4; k++) begin
            addr = 32'h40 + k * 4;
            send(OP_SW, addr, '0, 32'h1122_3344);
            send(OP_SB, addr, 12'(k), 32'h5A5A_5A00 + k);
            send(OP_LW, addr, '0, '0);
            send(OP_SH, addr, 12'((k % 2) * 2), 32'hBEEF_C0DE);
            send(OP_LW, addr, '0, '0);
        end

        test_name = "load_extension";
        for (int k = 0; k < 6; k++) begin
            addr    = 32'h80 + k * 4;
            pattern = (k == 0) ? 32'h80FF_7F01 : ((k == 1) ? 32'h7F01_80FF : $urandom());
            send(OP_SW, addr, '0, pattern);
            for (int b = 0; b < 4; b++) begin
                send(OP_LB, addr, 12'(b), '0);
                send(OP_LBU, addr + b, '0, '0);
            end
            for (int h = 0; h < 4; h += 2) begin
                send(OP_LH, addr, 12'(h), '0);
                send(OP_LHU, addr + h, '0, '0);
            end
            send(OP_LW, addr, '0, '0);
        end

        test_name = "misaligned";
        addr = 32'h100;
        send(OP_SW, addr, '0, 32'hCAFE_F00D);
        send(OP_SH, addr, 12'd1, 32'h1111_1111);
        send(OP_SH, addr + 3, '0, 32'h2222_2222);
        send(OP_SW, addr, 12'd2, 32'h3333_3333);
        send(OP_SW, addr + 4, 12'hFFD, 32'h4444_4444);
        send(OP_LH, addr, 12'd1, '0);
        send(OP_LHU, addr + 3, '0, '0);
        send(OP_LW, addr + 2, '0, '0);
        send(OP_LW, addr, 12'd3, '0);
        send(OP_LW, addr, '0, '0);

        test_name    = "back_pressure";
        ready_random = 1'b1;
        for (int n = 0; n < 200; n++) begin
            if (n % 10 == 0) begin
                addr = $urandom() & ~32'h3;
                send(OP_SW, addr, '0, $urandom());
                send(OP_LW, addr, '0, '0);
            end else begin
                send(lsu_op_e'(3'($urandom_range(0, 7))), $urandom(), 12'($urandom()),
                     $urandom());
            end
            gap = int'($urandom_range(0, 2));
            idle(gap);
        end
        drain();
        ready_random = 1'b0;
        idle(2);

        test_name = "latency";
        lat_check = 1'b1;
        for (int n = 0; n < 3; n++) begin
            send(OP_LW, 32'h40 + n * 4, '0, '0);
            drain();
        end
        for (int n = 0; n < 8; n++) begin
            send(OP_LW, 32'h80 + n * 4, '0, '0);
        end
        drain();
        lat_check = 1'b0;
        idle(2);

        print_counts();
        if (mismatches == 0 && other_errors == 0 && u_lsu_top.u_sva.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
hdl/lsu_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_sram.sv
hdl/lsu_load_align.sv
hdl/lsu_top.sv
verif/lsu_sva.sv
verif/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
